// File: design/mipsConsts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Instruction word geometry
`define INSTR_W 32
`define OP_W 6
`define FUNCT_W 6
`define REG_W 5

`define OP_MSB 31
`define OP_LSB 26
`define RS_MSB 25
`define RS_LSB 21
`define RT_MSB 20
`define RT_LSB 16
`define RD_MSB 15
`define RD_LSB 11
`define SHAMT_MSB 10
`define SHAMT_LSB 6
`define FUNCT_MSB 5
`define FUNCT_LSB 0

// Exception codes as seen in the Cause register
`define EXC_W 5
`define EXC_RI 5'd10
`define EXC_BP 5'd9
`define EXC_SYS 5'd8

`endif

// File: design/isaPkg.sv
`include "mipsConsts.svh"

package isaPkg;

	// Primary opcodes of the supported instructions
	typedef enum logic [`OP_W-1:0] {
		OP_SPECIAL = 6'o00,
		OP_REGIMM = 6'o01,
		OP_J = 6'o02,
		OP_JAL = 6'o03,
		OP_BEQ = 6'o04,
		OP_BNE = 6'o05,
		OP_BLEZ = 6'o06,
		OP_BGTZ = 6'o07,
		OP_ADDI = 6'o10,
		OP_ADDIU = 6'o11,
		OP_SLTI = 6'o12,
		OP_SLTIU = 6'o13,
		OP_ANDI = 6'o14,
		OP_ORI = 6'o15,
		OP_XORI = 6'o16,
		OP_LUI = 6'o17,
		OP_BEQL = 6'o24,
		OP_BNEL = 6'o25,
		OP_BLEZL = 6'o26,
		OP_BGTZL = 6'o27,
		OP_LB = 6'o40,
		OP_LH = 6'o41,
		OP_LWL = 6'o42,
		OP_LW = 6'o43,
		OP_LBU = 6'o44,
		OP_LHU = 6'o45,
		OP_LWR = 6'o46,
		OP_SB = 6'o50,
		OP_SH = 6'o51,
		OP_SWL = 6'o52,
		OP_SW = 6'o53,
		OP_SWR = 6'o56,
		OP_LL = 6'o60,
		OP_SC = 6'o70
	} opcodeT;

	// SPECIAL function field
	typedef enum logic [`FUNCT_W-1:0] {
		FN_SLL = 6'o00,
		FN_SRL = 6'o02,
		FN_SRA = 6'o03,
		FN_SLLV = 6'o04,
		FN_SRLV = 6'o06,
		FN_SRAV = 6'o07,
		FN_JR = 6'o10,
		FN_JALR = 6'o11,
		FN_SYSCALL = 6'o14,
		FN_BREAK = 6'o15,
		FN_SYNC = 6'o17,
		FN_ADD = 6'o40,
		FN_ADDU = 6'o41,
		FN_SUB = 6'o42,
		FN_SUBU = 6'o43,
		FN_AND = 6'o44,
		FN_OR = 6'o45,
		FN_XOR = 6'o46,
		FN_NOR = 6'o47,
		FN_SLT = 6'o52,
		FN_SLTU = 6'o53
	} functT;

	// REGIMM branches, selected by the rt field
	typedef enum logic [`REG_W-1:0] {
		RI_BLTZ = 5'b00000,
		RI_BGEZ = 5'b00001,
		RI_BLTZL = 5'b00010,
		RI_BGEZL = 5'b00011,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001,
		RI_BLTZALL = 5'b10010,
		RI_BGEZALL = 5'b10011
	} regimmT;

	typedef logic [`REG_W-1:0] regIdxT;

endpackage

// File: design/ctrlPkg.sv
package ctrlPkg;

	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_OR = 5'd2,
		ALU_AND = 5'd3,
		ALU_NOR = 5'd4,
		ALU_XOR = 5'd5,
		ALU_SLL = 5'd6,
		ALU_SRL = 5'd7,
		ALU_SRA = 5'd8,
		ALU_SLT = 5'd9,
		ALU_SLTU = 5'd10,
		ALU_ADDU = 5'd12,
		ALU_SUBU = 5'd16,
		ALU_NONE = 5'd31
	} aluOpT;

	typedef enum logic [1:0] {
		EXT_ZERO = 2'd0,
		EXT_SIGN = 2'd1,
		EXT_UPPER = 2'd2 // Immediate into the upper half
	} extOpT;

	typedef enum logic [1:0] {
		DEST_RT = 2'd0,
		DEST_RD = 2'd1,
		DEST_R31 = 2'd2
	} destSelT;

	// Write-back mux source
	typedef enum logic [2:0] {
		WB_IMM = 3'd1,
		WB_ALU = 3'd2,
		WB_LINK = 3'd3,
		WB_MEM = 3'd4,
		WB_SC = 3'd7 // SC success flag
	} wbSelT;

	typedef enum logic [3:0] {
		MEM_SB = 4'd0,
		MEM_SH = 4'd1,
		MEM_SW = 4'd2,
		MEM_SWL = 4'd3,
		MEM_SWR = 4'd4,
		MEM_LBU = 4'd5,
		MEM_LB = 4'd6,
		MEM_LHU = 4'd7,
		MEM_LH = 4'd8,
		MEM_LWL = 4'd9,
		MEM_LWR = 4'd10,
		MEM_LW = 4'd11
	} memSelT;

	typedef enum logic [1:0] {
		NPC_SEQ = 2'd0,
		NPC_BRANCH = 2'd1,
		NPC_JUMP = 2'd2,
		NPC_JREG = 2'd3
	} npcOpT;

endpackage

// File: design/intDecode.sv
module intDecode (
	input isaPkg::opcodeT op,
	input isaPkg::functT funct,
	input isaPkg::regIdxT rt,
	output ctrlPkg::aluOpT aluOp,
	output ctrlPkg::extOpT extOp,
	output logic shiftImmSel,
	output logic regWrite,
	output ctrlPkg::destSelT destSel,
	output ctrlPkg::wbSelT wbSel,
	output logic intLegal
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic linkBr; // REGIMM branch that writes the return address

	assign linkBr = (op == OP_REGIMM) &&
		(regimmT'(rt) inside {RI_BLTZAL, RI_BGEZAL, RI_BLTZALL, RI_BGEZALL});

	// Shift amount comes from shamt, not from rs
	assign shiftImmSel = (op == OP_SPECIAL) && (funct inside {FN_SLL, FN_SRL, FN_SRA});

	always_comb begin
		aluOp = ALU_NONE;
		extOp = EXT_ZERO;
		case (op)
			OP_SPECIAL: begin
				case (funct)
					FN_ADD: aluOp = ALU_ADD;
					FN_ADDU: aluOp = ALU_ADDU;
					FN_SUB: aluOp = ALU_SUB;
					FN_SUBU: aluOp = ALU_SUBU;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_XOR: aluOp = ALU_XOR;
					FN_NOR: aluOp = ALU_NOR;
					FN_SLT: aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					FN_SLL, FN_SLLV: aluOp = ALU_SLL;
					FN_SRL, FN_SRLV: aluOp = ALU_SRL;
					FN_SRA, FN_SRAV: aluOp = ALU_SRA;
					default: aluOp = ALU_NONE;
				endcase
			end
			// Address generation uses the same adder as ADDI
			OP_ADDI, OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR, OP_LL,
			OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR, OP_SC: begin
				aluOp = ALU_ADD;
				extOp = EXT_SIGN;
			end
			OP_ADDIU: begin
				aluOp = ALU_ADDU;
				extOp = EXT_SIGN;
			end
			OP_SLTI: begin
				aluOp = ALU_SLT;
				extOp = EXT_SIGN;
			end
			OP_SLTIU: begin
				aluOp = ALU_SLTU;
				extOp = EXT_SIGN;
			end
			OP_ANDI: aluOp = ALU_AND;
			OP_ORI: aluOp = ALU_OR;
			OP_XORI: aluOp = ALU_XOR;
			OP_LUI: begin
				aluOp = ALU_OR; // Result unused, write-back takes the immediate
				extOp = EXT_UPPER;
			end
			default: aluOp = ALU_NONE;
		endcase
	end

	always_comb begin
		regWrite = 1'b0;
		destSel = DEST_RT;
		wbSel = WB_ALU;
		intLegal = 1'b0;
		case (op)
			OP_SPECIAL: begin
				destSel = DEST_RD;
				if (funct == FN_JALR) begin
					regWrite = 1'b1;
					wbSel = WB_LINK;
				end else if (aluOp != ALU_NONE) begin
					regWrite = 1'b1;
					intLegal = 1'b1;
				end
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
				regWrite = 1'b1;
				intLegal = 1'b1;
			end
			OP_LUI: begin
				regWrite = 1'b1;
				wbSel = WB_IMM;
				intLegal = 1'b1;
			end
			OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR, OP_LL: begin
				regWrite = 1'b1;
				wbSel = WB_MEM;
			end
			OP_SC: begin
				regWrite = 1'b1; // rt receives the success flag
				wbSel = WB_SC;
			end
			OP_JAL: begin
				regWrite = 1'b1;
				destSel = DEST_R31;
				wbSel = WB_LINK;
			end
			OP_REGIMM: begin
				if (linkBr) begin
					regWrite = 1'b1;
					destSel = DEST_R31;
					wbSel = WB_LINK;
				end
			end
			default: regWrite = 1'b0;
		endcase
	end

	// A write with no ALU work must take its data from another source
	wrSrcChk: assert final (!regWrite || aluOp != ALU_NONE ||
		wbSel inside {WB_MEM, WB_LINK, WB_SC})
		else $error("intDecode: register write without a data source");

endmodule

// File: design/memDecode.sv
module memDecode (
	input isaPkg::opcodeT op,
	output logic memRead,
	output logic memWrite,
	output ctrlPkg::memSelT memSel,
	output logic llOp,
	output logic scOp,
	output logic memLegal
);
	import isaPkg::*;
	import ctrlPkg::*;

	assign llOp = (op == OP_LL);
	assign scOp = (op == OP_SC);
	assign memLegal = memRead || memWrite;

	always_comb begin
		memRead = 1'b0;
		memWrite = 1'b0;
		memSel = MEM_LW; // Word access when idle
		case (op)
			OP_LB: memSel = MEM_LB;
			OP_LBU: memSel = MEM_LBU;
			OP_LH: memSel = MEM_LH;
			OP_LHU: memSel = MEM_LHU;
			OP_LWL: memSel = MEM_LWL;
			OP_LWR: memSel = MEM_LWR;
			OP_SB: memSel = MEM_SB;
			OP_SH: memSel = MEM_SH;
			OP_SWL: memSel = MEM_SWL;
			OP_SWR: memSel = MEM_SWR;
			OP_SW, OP_SC: memSel = MEM_SW;
			default: memSel = MEM_LW; // LW and LL
		endcase
		case (op)
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL: memRead = 1'b1;
			OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC: memWrite = 1'b1;
			default: memRead = 1'b0;
		endcase
	end

	rdWrChk: assert final (!(memRead && memWrite))
		else $error("memDecode: read and write in one access");

endmodule

// File: design/branchResolve.sv
module branchResolve (
	input isaPkg::opcodeT op,
	input isaPkg::functT funct,
	input isaPkg::regIdxT rt,
	input logic cmpEq,
	input logic [3:0] cmpSign, // GEZ, LTZ, GTZ, LEZ from MSB down
	output logic isBranch,
	output ctrlPkg::npcOpT npcOp,
	output logic likelyFlush,
	output logic brLegal
);
	import isaPkg::*;
	import ctrlPkg::*;

	typedef enum logic [2:0] {
		COND_EQ,
		COND_NE,
		COND_GEZ,
		COND_LTZ,
		COND_LEZ,
		COND_GTZ
	} condT;

	condT cond;
	logic condBr; // Conditional branch form recognized
	logic likely;
	logic condHolds;
	logic jump;
	logic jumpReg;

	always_comb begin
		cond = COND_EQ;
		condBr = 1'b1;
		likely = 1'b0;
		case (op)
			OP_BEQ: cond = COND_EQ;
			OP_BNE: cond = COND_NE;
			OP_BLEZ: cond = COND_LEZ;
			OP_BGTZ: cond = COND_GTZ;
			OP_BEQL: begin
				cond = COND_EQ;
				likely = 1'b1;
			end
			OP_BNEL: begin
				cond = COND_NE;
				likely = 1'b1;
			end
			OP_BLEZL, OP_BGTZL: begin
				cond = (op == OP_BLEZL) ? COND_LEZ : COND_GTZ;
				likely = 1'b1;
				condBr = (rt == '0); // Nonzero rt is reserved
			end
			OP_REGIMM: begin
				cond = rt[0] ? COND_GEZ : COND_LTZ;
				likely = rt[1];
				condBr = (regimmT'(rt) inside {RI_BLTZ, RI_BGEZ, RI_BLTZL, RI_BGEZL,
					RI_BLTZAL, RI_BGEZAL, RI_BLTZALL, RI_BGEZALL});
			end
			default: condBr = 1'b0;
		endcase
	end

	always_comb begin
		case (cond)
			COND_EQ: condHolds = cmpEq;
			COND_NE: condHolds = !cmpEq;
			COND_GEZ: condHolds = cmpSign[3];
			COND_LTZ: condHolds = cmpSign[2];
			COND_GTZ: condHolds = cmpSign[1];
			default: condHolds = cmpSign[0]; // LEZ
		endcase
	end

	assign jump = (op == OP_J) || (op == OP_JAL);
	assign jumpReg = (op == OP_SPECIAL) && (funct inside {FN_JR, FN_JALR});

	always_comb begin
		if (condBr && condHolds)
			npcOp = NPC_BRANCH;
		else if (jump)
			npcOp = NPC_JUMP;
		else if (jumpReg)
			npcOp = NPC_JREG;
		else
			npcOp = NPC_SEQ;
	end

	assign isBranch = condBr || jump || jumpReg;
	assign likelyFlush = condBr && likely && !condHolds; // Annul the delay slot
	assign brLegal = isBranch;

endmodule

// File: design/excDecode.sv
`include "mipsConsts.svh"

module excDecode (
	input isaPkg::opcodeT op,
	input isaPkg::functT funct,
	input logic intLegal,
	input logic memLegal,
	input logic brLegal,
	output logic exception,
	output logic [`EXC_W-1:0] excCode
);
	import isaPkg::*;

	logic sysOp;
	logic brkOp;
	logic syncOp;
	logic claimed; // Some decoder knows this encoding

	assign sysOp = (op == OP_SPECIAL) && (funct == FN_SYSCALL);
	assign brkOp = (op == OP_SPECIAL) && (funct == FN_BREAK);
	assign syncOp = (op == OP_SPECIAL) && (funct == FN_SYNC);
	assign claimed = intLegal || memLegal || brLegal || sysOp || brkOp || syncOp;

	always_comb begin
		exception = 1'b1;
		if (!claimed)
			excCode = `EXC_RI;
		else if (brkOp)
			excCode = `EXC_BP;
		else if (sysOp)
			excCode = `EXC_SYS;
		else begin
			exception = 1'b0;
			excCode = '0;
		end
	end

	codeChk: assert final (exception == (excCode != '0))
		else $error("excDecode: exception flag and code disagree");

endmodule

// File: design/idDecode.sv
`include "mipsConsts.svh"

module idDecode (
	input logic clk,
	input logic rst,
	input logic [`INSTR_W-1:0] instr,
	input logic instrValid,
	input logic cmpEq,
	input logic [3:0] cmpSign,
	output logic decValid,
	output ctrlPkg::aluOpT aluOp,
	output ctrlPkg::extOpT extOp,
	output logic shiftImmSel,
	output logic regWrite,
	output ctrlPkg::destSelT destSel,
	output ctrlPkg::wbSelT wbSel,
	output logic memRead,
	output logic memWrite,
	output ctrlPkg::memSelT memSel,
	output logic llOp,
	output logic scOp,
	output logic isBranch,
	output ctrlPkg::npcOpT npcOp,
	output logic likelyFlush,
	output logic exception,
	output logic [`EXC_W-1:0] excCode
);
	import isaPkg::*;
	import ctrlPkg::*;

	opcodeT op;
	functT funct;
	regIdxT rt;

	aluOpT aluOpNext;
	extOpT extOpNext;
	destSelT destSelNext;
	wbSelT wbSelNext;
	memSelT memSelNext;
	npcOpT npcOpNext;
	logic shiftImmSelNext;
	logic regWriteNext;
	logic memReadNext;
	logic memWriteNext;
	logic llOpNext;
	logic scOpNext;
	logic isBranchNext;
	logic likelyFlushNext;
	logic exceptionNext;
	logic [`EXC_W-1:0] excCodeNext;
	logic intLegal;
	logic memLegal;
	logic brLegal;

	// Field split
	assign op = opcodeT'(instr[`OP_MSB:`OP_LSB]);
	assign funct = functT'(instr[`FUNCT_MSB:`FUNCT_LSB]);
	assign rt = instr[`RT_MSB:`RT_LSB];

	intDecode uInt (
		.op(op),
		.funct(funct),
		.rt(rt),
		.aluOp(aluOpNext),
		.extOp(extOpNext),
		.shiftImmSel(shiftImmSelNext),
		.regWrite(regWriteNext),
		.destSel(destSelNext),
		.wbSel(wbSelNext),
		.intLegal(intLegal)
	);

	memDecode uMem (
		.op(op),
		.memRead(memReadNext),
		.memWrite(memWriteNext),
		.memSel(memSelNext),
		.llOp(llOpNext),
		.scOp(scOpNext),
		.memLegal(memLegal)
	);

	branchResolve uBr (
		.op(op),
		.funct(funct),
		.rt(rt),
		.cmpEq(cmpEq),
		.cmpSign(cmpSign),
		.isBranch(isBranchNext),
		.npcOp(npcOpNext),
		.likelyFlush(likelyFlushNext),
		.brLegal(brLegal)
	);

	excDecode uExc (
		.op(op),
		.funct(funct),
		.intLegal(intLegal),
		.memLegal(memLegal),
		.brLegal(brLegal),
		.exception(exceptionNext),
		.excCode(excCodeNext)
	);

	// Control outputs, cleared by reset
	always_ff @(posedge clk) begin
		if (!rst) begin
			decValid <= 1'b0;
			regWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			llOp <= 1'b0;
			scOp <= 1'b0;
			isBranch <= 1'b0;
			npcOp <= NPC_SEQ;
			likelyFlush <= 1'b0;
			exception <= 1'b0;
		end else begin
			decValid <= instrValid; // One-cycle pulse per strobe
			if (instrValid) begin
				regWrite <= regWriteNext;
				memRead <= memReadNext;
				memWrite <= memWriteNext;
				llOp <= llOpNext;
				scOp <= scOpNext;
				isBranch <= isBranchNext;
				npcOp <= npcOpNext;
				likelyFlush <= likelyFlushNext;
				exception <= exceptionNext;
			end
		end
	end

	// Payload selects
	always_ff @(posedge clk) begin
		if (instrValid) begin
			aluOp <= aluOpNext;
			extOp <= extOpNext;
			shiftImmSel <= shiftImmSelNext;
			destSel <= destSelNext;
			wbSel <= wbSelNext;
			memSel <= memSelNext;
			excCode <= excCodeNext;
		end
	end

	// Every strobe yields exactly one result, one cycle later
	validChk: assert property (@(posedge clk) disable iff (!rst)
		decValid == ($past(instrValid) && $past(rst)))
		else $error("idDecode: decValid does not follow instrValid");

endmodule

// File: verif/tbClock.sv
module tbClock (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Active low, held for 16 rising edges
	initial begin
		rst = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end
endmodule

// File: verif/idDecodeTb.sv
`include "mipsConsts.svh"

module idDecodeTb;
	import isaPkg::*;
	import ctrlPkg::*;

	typedef struct packed {
		logic [4:0] aluOp;
		logic [1:0] extOp;
		logic shiftImmSel;
		logic regWrite;
		logic [1:0] destSel;
		logic [2:0] wbSel;
		logic memRead;
		logic memWrite;
		logic [3:0] memSel;
		logic llOp;
		logic scOp;
		logic isBranch;
		logic [1:0] npcOp;
		logic likelyFlush;
		logic exception;
		logic [`EXC_W-1:0] excCode;
	} decT;

	logic clk;
	logic rst;
	logic [`INSTR_W-1:0] instr;
	logic instrValid;
	logic cmpEq;
	logic [3:0] cmpSign;
	logic decValid;
	aluOpT aluOp;
	extOpT extOp;
	logic shiftImmSel;
	logic regWrite;
	destSelT destSel;
	wbSelT wbSel;
	logic memRead;
	logic memWrite;
	memSelT memSel;
	logic llOp;
	logic scOp;
	logic isBranch;
	npcOpT npcOp;
	logic likelyFlush;
	logic exception;
	logic [`EXC_W-1:0] excCode;

	logic [31:0] seed;
	logic [`OP_W-1:0] keptOps[$];
	logic [`FUNCT_W-1:0] keptFuncts[$];
	logic [`REG_W-1:0] keptRts[$];
	decT pending[$]; // At most one result in flight
	decT lastExp;
	logic haveResult = 1'b0;
	int unsigned valueErrors = 0;
	int unsigned timeoutErrors = 0;
	int unsigned resultCount = 0;

	tbClock clkGen (
		.clk(clk),
		.rst(rst)
	);

	idDecode idDecode_inst (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.cmpEq(cmpEq),
		.cmpSign(cmpSign),
		.decValid(decValid),
		.aluOp(aluOp),
		.extOp(extOp),
		.shiftImmSel(shiftImmSel),
		.regWrite(regWrite),
		.destSel(destSel),
		.wbSel(wbSel),
		.memRead(memRead),
		.memWrite(memWrite),
		.memSel(memSel),
		.llOp(llOp),
		.scOp(scOp),
		.isBranch(isBranch),
		.npcOp(npcOp),
		.likelyFlush(likelyFlush),
		.exception(exception),
		.excCode(excCode)
	);

	// LCG step
	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Upper bits only, the low LCG bits cycle fast
	function automatic int unsigned pick(int unsigned n);
		return (nextRand() >> 8) % n;
	endfunction

	task automatic collectEncodings();
		opcodeT o;
		functT f;
		regimmT r;
		o = o.first();
		repeat (o.num()) begin
			keptOps.push_back(o);
			o = o.next();
		end
		repeat (4) begin // R-type and REGIMM get extra weight
			keptOps.push_back(OP_SPECIAL);
			keptOps.push_back(OP_REGIMM);
		end
		f = f.first();
		repeat (f.num()) begin
			keptFuncts.push_back(f);
			f = f.next();
		end
		r = r.first();
		repeat (r.num()) begin
			keptRts.push_back(r);
			r = r.next();
		end
	endtask

	function automatic logic [`INSTR_W-1:0] randomInstr();
		logic [`INSTR_W-1:0] ins;
		ins = nextRand();
		ins[`OP_MSB:`OP_LSB] = (pick(4) != 0) ? keptOps[pick(keptOps.size())] : pick(64);
		ins[`FUNCT_MSB:`FUNCT_LSB] = (pick(4) != 0) ?
			keptFuncts[pick(keptFuncts.size())] : pick(64);
		ins[`RT_MSB:`RT_LSB] = (pick(4) != 0) ? keptRts[pick(keptRts.size())] : pick(32);
		return ins;
	endfunction

	function automatic decT immAlu(decT d, logic [4:0] op, logic [1:0] ext);
		d.aluOp = op;
		d.extOp = ext;
		d.regWrite = 1'b1;
		return d;
	endfunction

	// Reference model of the decode stage
	function automatic decT expectedDecode(logic [`INSTR_W-1:0] ins, logic eq, logic [3:0] sgn);
		decT d;
		logic [`OP_W-1:0] o;
		logic [`FUNCT_W-1:0] f;
		logic [`REG_W-1:0] t;
		logic known;
		logic condBr;
		logic taken;
		logic likely;
		o = ins[`OP_MSB:`OP_LSB];
		f = ins[`FUNCT_MSB:`FUNCT_LSB];
		t = ins[`RT_MSB:`RT_LSB];
		d = '0;
		d.aluOp = ALU_NONE;
		d.wbSel = WB_ALU;
		known = 1'b1;
		condBr = 1'b0;
		taken = 1'b0;
		likely = 1'b0;
		case (o)
			OP_SPECIAL: begin
				d.destSel = DEST_RD;
				d.shiftImmSel = f inside {FN_SLL, FN_SRL, FN_SRA};
				case (f)
					FN_ADD: d.aluOp = ALU_ADD;
					FN_ADDU: d.aluOp = ALU_ADDU;
					FN_SUB: d.aluOp = ALU_SUB;
					FN_SUBU: d.aluOp = ALU_SUBU;
					FN_AND: d.aluOp = ALU_AND;
					FN_OR: d.aluOp = ALU_OR;
					FN_XOR: d.aluOp = ALU_XOR;
					FN_NOR: d.aluOp = ALU_NOR;
					FN_SLT: d.aluOp = ALU_SLT;
					FN_SLTU: d.aluOp = ALU_SLTU;
					FN_SLL, FN_SLLV: d.aluOp = ALU_SLL;
					FN_SRL, FN_SRLV: d.aluOp = ALU_SRL;
					FN_SRA, FN_SRAV: d.aluOp = ALU_SRA;
					FN_JR: d.npcOp = NPC_JREG;
					FN_JALR: begin
						d.npcOp = NPC_JREG;
						d.regWrite = 1'b1;
						d.wbSel = WB_LINK;
					end
					FN_SYSCALL: d.excCode = `EXC_SYS;
					FN_BREAK: d.excCode = `EXC_BP;
					FN_SYNC: known = 1'b1; // Barrier only
					default: known = 1'b0;
				endcase
				d.isBranch = f inside {FN_JR, FN_JALR};
				if (d.aluOp != ALU_NONE)
					d.regWrite = 1'b1;
			end
			OP_REGIMM: begin
				condBr = t inside {RI_BLTZ, RI_BGEZ, RI_BLTZL, RI_BGEZL,
					RI_BLTZAL, RI_BGEZAL, RI_BLTZALL, RI_BGEZALL};
				known = condBr;
				taken = (t inside {RI_BGEZ, RI_BGEZL, RI_BGEZAL, RI_BGEZALL}) ? sgn[3] : sgn[2];
				likely = t inside {RI_BLTZL, RI_BGEZL, RI_BLTZALL, RI_BGEZALL};
				if (t inside {RI_BLTZAL, RI_BGEZAL, RI_BLTZALL, RI_BGEZALL}) begin
					d.regWrite = 1'b1;
					d.destSel = DEST_R31;
					d.wbSel = WB_LINK;
				end
			end
			OP_J, OP_JAL: begin
				d.isBranch = 1'b1;
				d.npcOp = NPC_JUMP;
				if (o == OP_JAL) begin
					d.regWrite = 1'b1;
					d.destSel = DEST_R31;
					d.wbSel = WB_LINK;
				end
			end
			OP_BEQ, OP_BEQL: begin
				condBr = 1'b1;
				taken = eq;
				likely = (o == OP_BEQL);
			end
			OP_BNE, OP_BNEL: begin
				condBr = 1'b1;
				taken = !eq;
				likely = (o == OP_BNEL);
			end
			OP_BLEZ, OP_BLEZL: begin
				condBr = (o == OP_BLEZ) || (t == 0); // Likely form needs rt zero
				known = condBr;
				taken = sgn[0];
				likely = (o == OP_BLEZL);
			end
			OP_BGTZ, OP_BGTZL: begin
				condBr = (o == OP_BGTZ) || (t == 0);
				known = condBr;
				taken = sgn[1];
				likely = (o == OP_BGTZL);
			end
			OP_ADDI: d = immAlu(d, ALU_ADD, EXT_SIGN);
			OP_ADDIU: d = immAlu(d, ALU_ADDU, EXT_SIGN);
			OP_SLTI: d = immAlu(d, ALU_SLT, EXT_SIGN);
			OP_SLTIU: d = immAlu(d, ALU_SLTU, EXT_SIGN);
			OP_ANDI: d = immAlu(d, ALU_AND, EXT_ZERO);
			OP_ORI: d = immAlu(d, ALU_OR, EXT_ZERO);
			OP_XORI: d = immAlu(d, ALU_XOR, EXT_ZERO);
			OP_LUI: begin
				d = immAlu(d, ALU_OR, EXT_UPPER);
				d.wbSel = WB_IMM;
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL: begin
				d = immAlu(d, ALU_ADD, EXT_SIGN);
				d.wbSel = WB_MEM;
				d.memRead = 1'b1;
				d.llOp = (o == OP_LL);
			end
			OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC: begin
				d.aluOp = ALU_ADD;
				d.extOp = EXT_SIGN;
				d.memWrite = 1'b1;
				if (o == OP_SC) begin
					d.scOp = 1'b1;
					d.regWrite = 1'b1; // Success flag into rt
					d.wbSel = WB_SC;
				end
			end
			default: known = 1'b0;
		endcase
		case (o)
			OP_SB: d.memSel = MEM_SB;
			OP_SH: d.memSel = MEM_SH;
			OP_SW, OP_SC: d.memSel = MEM_SW;
			OP_SWL: d.memSel = MEM_SWL;
			OP_SWR: d.memSel = MEM_SWR;
			OP_LBU: d.memSel = MEM_LBU;
			OP_LB: d.memSel = MEM_LB;
			OP_LHU: d.memSel = MEM_LHU;
			OP_LH: d.memSel = MEM_LH;
			OP_LWL: d.memSel = MEM_LWL;
			OP_LWR: d.memSel = MEM_LWR;
			default: d.memSel = MEM_LW;
		endcase
		if (condBr) begin
			d.isBranch = 1'b1;
			d.npcOp = taken ? NPC_BRANCH : NPC_SEQ;
			d.likelyFlush = likely && !taken; // Annulled delay slot
		end
		if (!known)
			d.excCode = `EXC_RI;
		d.exception = (d.excCode != 0);
		return d;
	endfunction

	function automatic string testName(decT e);
		if (e.exception)
			return "exception";
		else if (e.memRead || e.memWrite)
			return "memory";
		else if (e.isBranch)
			return "branch";
		return "alu";
	endfunction

	task automatic checkField(string test, string field, logic [31:0] expVal, logic [31:0] actVal);
		assert (actVal === expVal) else begin
			$display("Fail %s %s expected %0h actual %0h", test, field, expVal, actVal);
			valueErrors++;
		end
	endtask

	task automatic compareAll(string test, decT e);
		checkField(test, "aluOp", e.aluOp, aluOp);
		checkField(test, "extOp", e.extOp, extOp);
		checkField(test, "shiftImmSel", e.shiftImmSel, shiftImmSel);
		checkField(test, "regWrite", e.regWrite, regWrite);
		checkField(test, "destSel", e.destSel, destSel);
		checkField(test, "wbSel", e.wbSel, wbSel);
		checkField(test, "memRead", e.memRead, memRead);
		checkField(test, "memWrite", e.memWrite, memWrite);
		checkField(test, "memSel", e.memSel, memSel);
		checkField(test, "llOp", e.llOp, llOp);
		checkField(test, "scOp", e.scOp, scOp);
		checkField(test, "isBranch", e.isBranch, isBranch);
		checkField(test, "npcOp", e.npcOp, npcOp);
		checkField(test, "likelyFlush", e.likelyFlush, likelyFlush);
		checkField(test, "exception", e.exception, exception);
		checkField(test, "excCode", e.excCode, excCode);
	endtask

	task automatic checkResetState();
		checkField("reset", "regWrite", 0, regWrite);
		checkField("reset", "memRead", 0, memRead);
		checkField("reset", "memWrite", 0, memWrite);
		checkField("reset", "llOp", 0, llOp);
		checkField("reset", "scOp", 0, scOp);
		checkField("reset", "isBranch", 0, isBranch);
		checkField("reset", "npcOp", NPC_SEQ, npcOp);
		checkField("reset", "likelyFlush", 0, likelyFlush);
		checkField("reset", "exception", 0, exception);
	endtask

	// Outputs are stable at the falling edge
	task automatic checkOutputs();
		decT cur;
		if (pending.size() > 0) begin
			cur = pending.pop_front();
			checkField("strobe", "decValid", 1, decValid);
			compareAll(testName(cur), cur);
			lastExp = cur;
			haveResult = 1'b1;
			resultCount++;
		end else begin
			checkField("strobe", "decValid", 0, decValid);
			if (haveResult)
				compareAll("hold", lastExp);
			else
				checkResetState();
		end
	endtask

	task automatic driveNext();
		instr = randomInstr();
		cmpEq = pick(2);
		cmpSign = pick(16);
		instrValid = (pick(10) < 7);
		if (instrValid)
			pending.push_back(expectedDecode(instr, cmpEq, cmpSign));
	endtask

	task automatic waitResetRelease(output logic released);
		int cycles;
		cycles = 0;
		while (rst !== 1'b1 && cycles < 40) begin
			@(posedge clk);
			cycles++;
		end
		released = (rst === 1'b1);
	endtask

	initial begin
		logic released;
		instr = '0;
		instrValid = 1'b0;
		cmpEq = 1'b0;
		cmpSign = '0;
		seed = 32'h1db01be0;
		collectEncodings();
		waitResetRelease(released);
		if (released) begin
			for (int cycle = 0; cycle < 3000; cycle++) begin
				@(negedge clk);
				checkOutputs();
				driveNext();
			end
			@(negedge clk);
			checkOutputs();
			instrValid = 1'b0;
			@(negedge clk);
			checkOutputs();
		end else begin
			$display("Reset was not released within 40 cycles");
			timeoutErrors++;
		end
		$display("Results %0d, value errors %0d, timeout errors %0d",
			resultCount, valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end
endmodule

// File: tb.f
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/intDecode.sv
design/memDecode.sv
design/branchResolve.sv
design/excDecode.sv
design/idDecode.sv
verif/tbClock.sv
verif/idDecodeTb.sv

// File: Bender.yml
package:
  name: id_decode

sources:
  - include_dirs:
      - design
    files:
      - design/isaPkg.sv
      - design/ctrlPkg.sv
      - design/intDecode.sv
      - design/memDecode.sv
      - design/branchResolve.sv
      - design/excDecode.sv
      - design/idDecode.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tbClock.sv
      - verif/idDecodeTb.sv
